/* include/alu_params.svh */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Integer register and data path width
`define ALU_XLEN 64

// Word operations work on the low half
`define ALU_WORD_W 32

// I-type immediate field width
`define ALU_IMM_W 12

// Shift amounts, 64-bit and word forms
`define ALU_SHAMT_W 6
`define ALU_WORD_SHAMT_W 5

// Op code width, room for 64 codes
`define ALU_OP_W 6

`endif

/* hw/alu_pkg.sv */
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

  // Supported operations, codes 34 to 63 are undefined
  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD   = 6'd0,
    ALU_SUB   = 6'd1,
    ALU_AND   = 6'd2,
    ALU_OR    = 6'd3,
    ALU_XOR   = 6'd4,
    ALU_SLT   = 6'd5,
    ALU_SLTU  = 6'd6,
    ALU_SLL   = 6'd7,
    ALU_SRL   = 6'd8,
    ALU_SRA   = 6'd9,
    // Immediate forms
    ALU_ADDI  = 6'd10,
    ALU_XORI  = 6'd11,
    ALU_ORI   = 6'd12,
    ALU_ANDI  = 6'd13,
    ALU_SLTI  = 6'd14,
    ALU_SLTIU = 6'd15,
    ALU_SLLI  = 6'd16,
    ALU_SRLI  = 6'd17,
    ALU_SRAI  = 6'd18,
    // RV64 word forms
    ALU_ADDW  = 6'd19,
    ALU_SUBW  = 6'd20,
    ALU_SLLW  = 6'd21,
    ALU_SRLW  = 6'd22,
    ALU_SRAW  = 6'd23,
    ALU_ADDIW = 6'd24,
    ALU_SLLIW = 6'd25,
    ALU_SRLIW = 6'd26,
    ALU_SRAIW = 6'd27,
    // Branch compares, result is 1 or 0
    ALU_BEQ   = 6'd28,
    ALU_BNE   = 6'd29,
    ALU_BLT   = 6'd30,
    ALU_BGE   = 6'd31,
    ALU_BLTU  = 6'd32,
    ALU_BGEU  = 6'd33
  } alu_op_e;

  // Unit that owns the result
  typedef enum logic [1:0] {
    UNIT_NONE  = 2'd0,
    UNIT_ARITH = 2'd1,
    UNIT_SHIFT = 2'd2
  } alu_unit_e;

  // Function inside a unit
  typedef enum logic [3:0] {
    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
    FN_SLT, FN_SLTU, FN_EQ, FN_NE, FN_GE, FN_GEU,
    FN_SLL, FN_SRL, FN_SRA
  } alu_fn_e;

  // Request as presented with alu_enable
  typedef struct packed {
    alu_op_e                  op;
    logic [`ALU_XLEN-1:0]     operand1;
    logic [`ALU_XLEN-1:0]     operand2;
    logic [`ALU_IMM_W-1:0]    imm;
    logic [`ALU_SHAMT_W-1:0]  shamt;
  } alu_req_t;

  // Decoded operands shared by both units
  typedef struct packed {
    logic [`ALU_XLEN-1:0]     op_a;
    logic [`ALU_XLEN-1:0]     op_b;
    logic [`ALU_SHAMT_W-1:0]  shift_amt;
    alu_fn_e                  fn;
    alu_unit_e                unit;
    logic                     word;
  } alu_opnd_t;

endpackage

`default_nettype wire

/* hw/alu_operand_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_params.svh"

module alu_operand_select
  import alu_pkg::*;
(
  input  alu_req_t  req,
  output alu_opnd_t opnd
);

  // Immediate widened to full data width
  logic [`ALU_XLEN-1:0] imm_ext;
  // Per-op selection of operand B and shift source
  logic                 use_imm;
  logic                 use_shamt;
  alu_unit_e            unit;
  alu_fn_e              fn;
  logic                 word;

  // Sign bit of the I-type immediate fills the top
  assign imm_ext = {{(`ALU_XLEN-`ALU_IMM_W){req.imm[`ALU_IMM_W-1]}}, req.imm};

  always_comb begin
    // Undefined codes fall through to no unit
    unit      = UNIT_NONE;
    fn        = FN_ADD;
    word      = 1'b0;
    use_imm   = 1'b0;
    use_shamt = 1'b0;
    case (req.op)
      // Register forms
      ALU_ADD:   begin unit = UNIT_ARITH; fn = FN_ADD;  end
      ALU_SUB:   begin unit = UNIT_ARITH; fn = FN_SUB;  end
      ALU_AND:   begin unit = UNIT_ARITH; fn = FN_AND;  end
      ALU_OR:    begin unit = UNIT_ARITH; fn = FN_OR;   end
      ALU_XOR:   begin unit = UNIT_ARITH; fn = FN_XOR;  end
      ALU_SLT:   begin unit = UNIT_ARITH; fn = FN_SLT;  end
      ALU_SLTU:  begin unit = UNIT_ARITH; fn = FN_SLTU; end
      ALU_SLL:   begin unit = UNIT_SHIFT; fn = FN_SLL;  end
      ALU_SRL:   begin unit = UNIT_SHIFT; fn = FN_SRL;  end
      ALU_SRA:   begin unit = UNIT_SHIFT; fn = FN_SRA;  end
      // Immediate forms take imm_ext as operand B
      ALU_ADDI:  begin unit = UNIT_ARITH; fn = FN_ADD;  use_imm = 1'b1; end
      ALU_XORI:  begin unit = UNIT_ARITH; fn = FN_XOR;  use_imm = 1'b1; end
      ALU_ORI:   begin unit = UNIT_ARITH; fn = FN_OR;   use_imm = 1'b1; end
      ALU_ANDI:  begin unit = UNIT_ARITH; fn = FN_AND;  use_imm = 1'b1; end
      ALU_SLTI:  begin unit = UNIT_ARITH; fn = FN_SLT;  use_imm = 1'b1; end
      ALU_SLTIU: begin unit = UNIT_ARITH; fn = FN_SLTU; use_imm = 1'b1; end
      // Shift-immediate forms use shamt
      ALU_SLLI:  begin unit = UNIT_SHIFT; fn = FN_SLL;  use_shamt = 1'b1; end
      ALU_SRLI:  begin unit = UNIT_SHIFT; fn = FN_SRL;  use_shamt = 1'b1; end
      ALU_SRAI:  begin unit = UNIT_SHIFT; fn = FN_SRA;  use_shamt = 1'b1; end
      // Word forms, low 32 bits then sign-extend
      ALU_ADDW:  begin unit = UNIT_ARITH; fn = FN_ADD;  word = 1'b1; end
      ALU_SUBW:  begin unit = UNIT_ARITH; fn = FN_SUB;  word = 1'b1; end
      ALU_SLLW:  begin unit = UNIT_SHIFT; fn = FN_SLL;  word = 1'b1; end
      ALU_SRLW:  begin unit = UNIT_SHIFT; fn = FN_SRL;  word = 1'b1; end
      ALU_SRAW:  begin unit = UNIT_SHIFT; fn = FN_SRA;  word = 1'b1; end
      ALU_ADDIW: begin unit = UNIT_ARITH; fn = FN_ADD;  word = 1'b1; use_imm = 1'b1; end
      ALU_SLLIW: begin unit = UNIT_SHIFT; fn = FN_SLL;  word = 1'b1; use_shamt = 1'b1; end
      ALU_SRLIW: begin unit = UNIT_SHIFT; fn = FN_SRL;  word = 1'b1; use_shamt = 1'b1; end
      ALU_SRAIW: begin unit = UNIT_SHIFT; fn = FN_SRA;  word = 1'b1; use_shamt = 1'b1; end
      // Branch compares, BLT and BLTU reuse the set-less-than path
      ALU_BEQ:   begin unit = UNIT_ARITH; fn = FN_EQ;   end
      ALU_BNE:   begin unit = UNIT_ARITH; fn = FN_NE;   end
      ALU_BLT:   begin unit = UNIT_ARITH; fn = FN_SLT;  end
      ALU_BGE:   begin unit = UNIT_ARITH; fn = FN_GE;   end
      ALU_BLTU:  begin unit = UNIT_ARITH; fn = FN_SLTU; end
      ALU_BGEU:  begin unit = UNIT_ARITH; fn = FN_GEU;  end
      default:   unit = UNIT_NONE;
    endcase
  end

  // Operand A is always rs1
  assign opnd.op_a      = req.operand1;
  assign opnd.op_b      = use_imm ? imm_ext : req.operand2;
  // Register shifts take the low six bits of rs2
  assign opnd.shift_amt = use_shamt ? req.shamt : req.operand2[`ALU_SHAMT_W-1:0];
  assign opnd.fn        = fn;
  assign opnd.unit      = unit;
  assign opnd.word      = word;

endmodule

`default_nettype wire

/* hw/alu_arith_logic.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_params.svh"

module alu_arith_logic
  import alu_pkg::*;
(
  input  alu_opnd_t             opnd,
  output logic [`ALU_XLEN-1:0]  arith_result
);

  logic [`ALU_XLEN-1:0] sum;
  logic [`ALU_XLEN-1:0] diff;
  // Compare flags shared by SLT and branch forms
  logic                 lt_s;
  logic                 lt_u;
  logic                 eq;
  // Result before word-mode extension
  logic [`ALU_XLEN-1:0] raw;

  assign sum  = opnd.op_a + opnd.op_b;
  assign diff = opnd.op_a - opnd.op_b;

  // Signed view for SLT, SLTI, BLT, BGE
  assign lt_s = $signed(opnd.op_a) < $signed(opnd.op_b);
  // SLTIU compares against the extended immediate as unsigned
  assign lt_u = opnd.op_a < opnd.op_b;
  assign eq   = opnd.op_a == opnd.op_b;

  always_comb begin
    raw = '0;
    case (opnd.fn)
      FN_ADD:  raw = sum;
      FN_SUB:  raw = diff;
      FN_AND:  raw = opnd.op_a & opnd.op_b;
      FN_OR:   raw = opnd.op_a | opnd.op_b;
      FN_XOR:  raw = opnd.op_a ^ opnd.op_b;
      // Compares return 1 or 0 in bit 0
      FN_SLT:  raw = {{(`ALU_XLEN-1){1'b0}}, lt_s};
      FN_SLTU: raw = {{(`ALU_XLEN-1){1'b0}}, lt_u};
      FN_EQ:   raw = {{(`ALU_XLEN-1){1'b0}}, eq};
      FN_NE:   raw = {{(`ALU_XLEN-1){1'b0}}, ~eq};
      FN_GE:   raw = {{(`ALU_XLEN-1){1'b0}}, ~lt_s};
      FN_GEU:  raw = {{(`ALU_XLEN-1){1'b0}}, ~lt_u};
      // Shift functions belong to the other unit
      default: raw = '0;
    endcase
  end

  always_comb begin
    if (opnd.word) begin
      // ADDW, SUBW, ADDIW keep the low word and extend bit 31
      arith_result = {{(`ALU_XLEN-`ALU_WORD_W){raw[`ALU_WORD_W-1]}},
                      raw[`ALU_WORD_W-1:0]};
    end else begin
      arith_result = raw;
    end
  end

endmodule

`default_nettype wire

/* hw/alu_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_params.svh"

module alu_shifter
  import alu_pkg::*;
(
  input  alu_opnd_t             opnd,
  output logic [`ALU_XLEN-1:0]  shift_result
);

  // Word mode only sees the low half and five amount bits
  logic [`ALU_WORD_W-1:0]       w_src;
  logic [`ALU_WORD_SHAMT_W-1:0] w_amt;
  logic [`ALU_WORD_W-1:0]       word_shift;
  logic [`ALU_XLEN-1:0]         full_shift;

  assign w_src = opnd.op_a[`ALU_WORD_W-1:0];
  assign w_amt = opnd.shift_amt[`ALU_WORD_SHAMT_W-1:0];

  always_comb begin
    full_shift = '0;
    word_shift = '0;
    case (opnd.fn)
      FN_SLL: begin
        full_shift = opnd.op_a << opnd.shift_amt;
        word_shift = w_src << w_amt;
      end
      FN_SRL: begin
        // Zero fill
        full_shift = opnd.op_a >> opnd.shift_amt;
        word_shift = w_src >> w_amt;
      end
      FN_SRA: begin
        // Fill from bit 63, or from bit 31 in word mode
        full_shift = $signed(opnd.op_a) >>> opnd.shift_amt;
        word_shift = $signed(w_src) >>> w_amt;
      end
      default: begin
        full_shift = '0;
        word_shift = '0;
      end
    endcase
  end

  // Word results are sign-extended from bit 31
  assign shift_result = opnd.word ?
    {{(`ALU_XLEN-`ALU_WORD_W){word_shift[`ALU_WORD_W-1]}}, word_shift} : full_shift;

endmodule

`default_nettype wire

/* hw/alu_result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_params.svh"

module alu_result_stage
  import alu_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             alu_enable,
  input  alu_unit_e             unit,
  input  wire logic [`ALU_XLEN-1:0] arith_result,
  input  wire logic [`ALU_XLEN-1:0] shift_result,
  output logic [`ALU_XLEN-1:0]  result,
  output logic                  zero,
  output logic                  alu_complete
);

  logic [`ALU_XLEN-1:0] sel_result;
  logic                 sel_zero;

  // Undefined op codes produce 0
  always_comb begin
    case (unit)
      UNIT_ARITH: sel_result = arith_result;
      UNIT_SHIFT: sel_result = shift_result;
      default:    sel_result = '0;
    endcase
  end

  assign sel_zero = (sel_result == '0);

  // One-cycle output register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result       <= '0;
      zero         <= 1'b0;
      alu_complete <= 1'b0;
    end else begin
      // Complete pulses once per enabled cycle
      alu_complete <= alu_enable;
      // Result and zero hold while idle
      if (alu_enable) begin
        result <= sel_result;
        zero   <= sel_zero;
      end
    end
  end

  // Every completion traces back to an enabled cycle
  a_complete_after_enable: assert property (
    @(posedge clk) disable iff (!rst_n) alu_complete |-> $past(alu_enable)
  ) else $error("alu_complete without an enabled request one cycle earlier");

  // Registered flag agrees with the registered result
  a_zero_matches_result: assert property (
    @(posedge clk) disable iff (!rst_n) alu_complete |-> (zero == ~|result)
  ) else $error("zero flag disagrees with result");

  // Outputs stay known once out of reset
  a_outputs_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({result, zero, alu_complete})
  ) else $error("unknown value on ALU outputs");

endmodule

`default_nettype wire

/* hw/alu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_params.svh"

module alu_top
  import alu_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             alu_enable,
  input  alu_req_t              req,
  output logic [`ALU_XLEN-1:0]  result,
  output logic                  zero,
  output logic                  alu_complete
);

  // Decoded operands feed both units
  alu_opnd_t            opnd;
  logic [`ALU_XLEN-1:0] arith_result;
  logic [`ALU_XLEN-1:0] shift_result;

  // Decode and operand B / shift amount choice
  alu_operand_select u_operand_select (
    .req  (req),
    .opnd (opnd)
  );

  // Add, subtract, logic and compares
  alu_arith_logic u_arith_logic (
    .opnd         (opnd),
    .arith_result (arith_result)
  );

  // 64-bit and word shifts
  alu_shifter u_shifter (
    .opnd         (opnd),
    .shift_result (shift_result)
  );

  // Only registered stage, sets the one-cycle latency
  alu_result_stage u_result_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_enable   (alu_enable),
    .unit         (opnd.unit),
    .arith_result (arith_result),
    .shift_result (shift_result),
    .result       (result),
    .zero         (zero),
    .alu_complete (alu_complete)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_alu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_params.svh"

module tb_alu_top
  import alu_pkg::*;
();

  // Stimulus takes about 1600 cycles so the limit leaves ample margin
  localparam int MAX_CYCLES = 3000;

  logic                 clk;
  logic                 rst_n;
  logic                 alu_enable;
  alu_req_t             req;
  logic [`ALU_XLEN-1:0] result;
  logic                 zero;
  logic                 alu_complete;

  // Expected outputs trail the request by one cycle
  logic [`ALU_XLEN-1:0] model_value;
  logic [`ALU_XLEN-1:0] exp_result;
  logic                 exp_zero;
  logic                 exp_complete;

  int err_count;
  int pass_tests;
  int fail_tests;
  int test_errs_start;
  int cycles;

  alu_op_e rr_ops[13] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
                          ALU_ADDI, ALU_XORI, ALU_ORI, ALU_ANDI, ALU_SLTI, ALU_SLTIU};
  alu_op_e sh_ops[6]  = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLI, ALU_SRLI, ALU_SRAI};
  alu_op_e w_ops[9]   = '{ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
                          ALU_ADDIW, ALU_SLLIW, ALU_SRLIW, ALU_SRAIW};
  alu_op_e br_ops[6]  = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};

  tb_clock_gen #(.PERIOD_NS(4), .RST_CYCLES(4)) u_clock_gen (.clk(clk), .rst_n(rst_n));

  alu_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_enable   (alu_enable),
    .req          (req),
    .result       (result),
    .zero         (zero),
    .alu_complete (alu_complete)
  );

  // Word results carry bit 31 into the upper half
  function automatic logic [63:0] sext32(logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // Arithmetic right shift as logical shift plus a mask of ones
  function automatic logic [63:0] sra64(logic [63:0] v, int unsigned s);
    return (v >> s) | (v[63] ? ~(64'hFFFF_FFFF_FFFF_FFFF >> s) : 64'h0);
  endfunction

  function automatic logic [31:0] sra32(logic [31:0] v, int unsigned s);
    return (v >> s) | (v[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0);
  endfunction

  function automatic logic [63:0] flag(logic c);
    return c ? 64'd1 : 64'd0;
  endfunction

  // Reference model from the RV64I rules
  function automatic logic [63:0] expect_value(alu_req_t r);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] i;
    a = r.operand1;
    b = r.operand2;
    i = {{52{r.imm[11]}}, r.imm};
    case (r.op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_AND:   return a & b;
      ALU_OR:    return a | b;
      ALU_XOR:   return a ^ b;
      ALU_SLT:   return flag($signed(a) < $signed(b));
      ALU_SLTU:  return flag(a < b);
      ALU_SLL:   return a << b[5:0];
      ALU_SRL:   return a >> b[5:0];
      ALU_SRA:   return sra64(a, b[5:0]);
      ALU_ADDI:  return a + i;
      ALU_XORI:  return a ^ i;
      ALU_ORI:   return a | i;
      ALU_ANDI:  return a & i;
      ALU_SLTI:  return flag($signed(a) < $signed(i));
      ALU_SLTIU: return flag(a < i);
      ALU_SLLI:  return a << r.shamt;
      ALU_SRLI:  return a >> r.shamt;
      ALU_SRAI:  return sra64(a, r.shamt);
      ALU_ADDW:  return sext32(a[31:0] + b[31:0]);
      ALU_SUBW:  return sext32(a[31:0] - b[31:0]);
      ALU_SLLW:  return sext32(a[31:0] << b[4:0]);
      ALU_SRLW:  return sext32(a[31:0] >> b[4:0]);
      ALU_SRAW:  return sext32(sra32(a[31:0], b[4:0]));
      ALU_ADDIW: return sext32(a[31:0] + i[31:0]);
      ALU_SLLIW: return sext32(a[31:0] << r.shamt[4:0]);
      ALU_SRLIW: return sext32(a[31:0] >> r.shamt[4:0]);
      ALU_SRAIW: return sext32(sra32(a[31:0], r.shamt[4:0]));
      ALU_BEQ:   return flag(a == b);
      ALU_BNE:   return flag(a != b);
      ALU_BLT:   return flag($signed(a) < $signed(b));
      ALU_BGE:   return flag($signed(a) >= $signed(b));
      ALU_BLTU:  return flag(a < b);
      ALU_BGEU:  return flag(a >= b);
      default:   return 64'h0;
    endcase
  endfunction

  always_comb model_value = expect_value(req);

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_complete <= 1'b0;
      exp_result   <= '0;
      exp_zero     <= 1'b0;
    end else begin
      exp_complete <= alu_enable;
      // Outputs hold while idle
      if (alu_enable) begin
        exp_result <= model_value;
        exp_zero   <= (model_value == '0);
      end
    end
  end

  task automatic value_error(string sig, logic [63:0] exp, logic [63:0] act);
    err_count++;
    $display("[ERROR] %s expected %h got %h at %0t", sig, exp, act, $time);
  endtask

  a_complete_value: assert property (@(posedge clk) disable iff (!rst_n)
    alu_complete == exp_complete)
    else value_error("alu_complete", $sampled(exp_complete), $sampled(alu_complete));

  a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
    result == exp_result)
    else value_error("result", $sampled(exp_result), $sampled(result));

  a_zero_value: assert property (@(posedge clk) disable iff (!rst_n)
    zero == exp_zero)
    else value_error("zero", $sampled(exp_zero), $sampled(zero));

  // Flag must agree with the value it came with
  a_zero_rule: assert property (@(posedge clk) disable iff (!rst_n)
    alu_complete |-> (zero == (result == '0)))
    else begin
      err_count++;
      $display("zero flag does not match the completed result at %0t", $time);
    end

  a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rst_n) |-> (result == '0 && !zero && !alu_complete))
    else begin
      err_count++;
      $display("outputs were not cleared by reset at %0t", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Edge values hit the signed and unsigned compare boundaries
  function automatic logic [63:0] rand_operand();
    case ($urandom_range(7))
      0: return 64'h0;
      1: return 64'hFFFF_FFFF_FFFF_FFFF;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h7FFF_FFFF_FFFF_FFFF;
      4: return {32'h0, $urandom()};
      default: return {$urandom(), $urandom()};
    endcase
  endfunction

  function automatic logic [5:0] rand_amount();
    case ($urandom_range(3))
      0: return 6'd0;
      1: return 6'd63;
      default: return 6'($urandom_range(63));
    endcase
  endfunction

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clk);
      alu_enable = 1'b0;
    end
  endtask

  task automatic issue(alu_op_e op, logic [63:0] a, logic [63:0] b,
                       logic [11:0] imm, logic [5:0] shamt);
    @(negedge clk);
    alu_enable   = 1'b1;
    req.op       = op;
    req.operand1 = a;
    req.operand2 = b;
    req.imm      = imm;
    req.shamt    = shamt;
  endtask

  // Random gap of 1 to 3 idle cycles after about a quarter of requests
  task automatic issue_gapped(alu_op_e op, logic [63:0] a, logic [63:0] b);
    issue(op, a, b, 12'($urandom()), rand_amount());
    if ($urandom_range(3) == 0)
      idle($urandom_range(3, 1));
  endtask

  // Drain the last completion before the report
  task automatic finish_test(string name);
    int errs;
    idle(2);
    errs = err_count - test_errs_start;
    if (errs == 0) begin
      pass_tests++;
      $display("[PASS] %s", name);
    end else begin
      fail_tests++;
      $display("[FAIL] %s with %0d errors", name, errs);
    end
    test_errs_start = err_count;
  endtask

  initial begin
    logic [63:0] a;
    err_count       = 0;
    pass_tests      = 0;
    fail_tests      = 0;
    test_errs_start = 0;
    cycles          = 0;
    alu_enable      = 1'b0;
    req             = '0;
    void'($urandom(57796));
    @(posedge rst_n);
    idle(6);
    finish_test("reset and idle");

    // Back-to-back burst followed by gapped requests
    repeat (24) issue(ALU_ADD, rand_operand(), rand_operand(), 12'h0, 6'h0);
    repeat (40) issue_gapped(rr_ops[$urandom_range(12)], rand_operand(), rand_operand());
    finish_test("latency and throughput");

    issue(ALU_ADDI, 64'd5, 64'd0, 12'h800, 6'd0);
    issue(ALU_SLTIU, 64'h10, 64'd0, 12'hFFF, 6'd0);
    issue(ALU_SLTI, 64'h10, 64'd0, 12'hFFF, 6'd0);
    repeat (400) issue_gapped(rr_ops[$urandom_range(12)], rand_operand(), rand_operand());
    finish_test("register and immediate operations");

    issue(ALU_SLL, rand_operand(), {58'h3, 6'd63}, 12'h0, 6'd0);
    issue(ALU_SRL, rand_operand(), {58'h1, 6'd0}, 12'h0, 6'd0);
    issue(ALU_SRA, 64'hF000_0000_0000_0000, 64'd4, 12'h0, 6'd0);
    issue(ALU_SRAI, 64'h8000_0000_0000_0001, 64'd0, 12'h0, 6'd63);
    issue(ALU_SLLI, 64'h1, 64'd0, 12'h0, 6'd0);
    repeat (200) issue_gapped(sh_ops[$urandom_range(5)], rand_operand(), rand_operand());
    finish_test("shifts");

    // Overflow past the largest positive word
    issue(ALU_ADDW, 64'h7FFF_FFFF, 64'd1, 12'h0, 6'd0);
    issue(ALU_SRLW, 64'h0000_0000_8000_0000, 64'd0, 12'h0, 6'd0);
    issue(ALU_SRLIW, 64'hFFFF_FFFF_8000_1234, 64'd0, 12'h0, 6'd0);
    issue(ALU_ADDIW, 64'h7FFF_FFFF, 64'd0, 12'h001, 6'd0);
    repeat (200) issue_gapped(w_ops[$urandom_range(8)], rand_operand(), rand_operand());
    finish_test("word operations");

    a = rand_operand();
    foreach (br_ops[k]) issue(br_ops[k], a, a, 12'h0, 6'd0);
    foreach (br_ops[k]) issue(br_ops[k], 64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF,
                              12'h0, 6'd0);
    foreach (br_ops[k]) issue(br_ops[k], 64'h0, 64'hFFFF_FFFF_FFFF_FFFF, 12'h0, 6'd0);
    // A zero result followed by undefined codes
    issue(ALU_SUB, a, a, 12'h0, 6'd0);
    issue(alu_op_e'(6'd34), a, a, 12'h0, 6'd0);
    issue(alu_op_e'(6'd47), rand_operand(), rand_operand(), 12'h0, 6'd0);
    issue(alu_op_e'(6'd63), rand_operand(), rand_operand(), 12'h0, 6'd0);
    repeat (150) begin
      a = rand_operand();
      issue_gapped(br_ops[$urandom_range(5)], a, ($urandom_range(3) == 0) ? a : rand_operand());
    end
    finish_test("branch compares, zero flag and undefined codes");

    $display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* alu_rv64.f */
+incdir+include
hw/alu_pkg.sv
hw/alu_operand_select.sv
hw/alu_arith_logic.sv
hw/alu_shifter.sv
hw/alu_result_stage.sv
hw/alu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_alu_top.sv
